// File: rtl/cachePkg.sv
`default_nettype none

package cachePkg;

  // 256 sets of 16-byte lines, 32-bit addresses
  parameter int IndexBits = 8;
  parameter int OffsetBits = 4;
  parameter int TagBits = 32 - IndexBits - OffsetBits;
  parameter int Sets = 1 << IndexBits;
  parameter int WordsPerLine = 4;

  typedef struct packed {
    logic               valid;
    logic [TagBits-1:0] tag;
  } tagEntryT;

  // word 0 sits at the lowest address of the line
  typedef logic [WordsPerLine-1:0][31:0] lineT;

  typedef enum logic [1:0] {
    Idle,
    Lookup,
    Miss,
    Refill
  } cacheStateT;

endpackage

`default_nettype wire

// File: rtl/busPkg.sv
`default_nettype none

package busPkg;

  // fetch unit side
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } fetchReqT;

  typedef struct packed {
    logic        dataOk;  // one-cycle pulse
    logic [31:0] rdata;
  } fetchRespT;

  // refill side, one 128-bit beat per line
  typedef struct packed {
    logic        rdReq;
    logic [31:0] rdAddr;  // line aligned
  } refillReqT;

  typedef struct packed {
    logic         retValid;
    logic [127:0] retData;
  } refillRetT;

  // per-cycle events for the performance counters
  typedef struct packed {
    logic accepted;
    logic miss;
  } lookupEvtT;

endpackage

`default_nettype wire

// File: rtl/cacheRam.sv
`default_nettype none

module cacheRam #(
  parameter int  Depth    = 256,
  parameter type payloadT = logic [31:0]
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [$clog2(Depth)-1:0] addr,
  input  payloadT                  wdata,
  output payloadT                  rdata
);

  payloadT mem [Depth];

  // single port, registered read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
        rdata <= wdata;  // write-first, new entry visible next cycle
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/iCache.sv
`default_nettype none

module iCache (
  input  logic                           clk,
  input  logic                           resetn,
  input  busPkg::fetchReqT               fetchReq,
  output logic                           addrOk,
  output busPkg::fetchRespT              fetchResp,
  input  logic                           flush,
  output busPkg::refillReqT              refillReq,
  input  logic                           rdRdy,
  input  busPkg::refillRetT              refillRet,
  output logic                           tagEn,
  output logic                           tagWe0,
  output logic                           tagWe1,
  output logic [cachePkg::IndexBits-1:0] ramIndex,
  output cachePkg::tagEntryT             tagWdata,
  input  cachePkg::tagEntryT             tagRdata0,
  input  cachePkg::tagEntryT             tagRdata1,
  output cachePkg::lineT                 dataWdata,
  input  cachePkg::lineT                 dataRdata0,
  input  cachePkg::lineT                 dataRdata1,
  output busPkg::lookupEvtT              lookupEvt
);

  import cachePkg::*;

  cacheStateT state;
  cacheStateT nextState;

  logic [31:0]     reqBuf;     // fetch address of the lookup
  logic            replay;     // line written, lookup still owed
  logic            flushPend;  // flush seen during miss or refill
  logic [Sets-1:0] lru;        // way to replace next, one bit per set

  logic [TagBits-1:0]              bufTag;
  logic [IndexBits-1:0]            bufIndex;
  logic [$clog2(WordsPerLine)-1:0] bufWord;
  logic [IndexBits-1:0]            newIndex;

  logic        hit0;
  logic        hit1;
  logic        hit;
  logic        respOk;
  logic        accept;
  logic        replayRead;
  logic        refillWr;
  logic        victim;
  logic [31:0] word0;
  logic [31:0] word1;

  // address fields
  assign bufTag = reqBuf[31 -: TagBits];
  assign bufIndex = reqBuf[OffsetBits +: IndexBits];
  assign bufWord = reqBuf[2 +: $clog2(WordsPerLine)];
  assign newIndex = fetchReq.addr[OffsetBits +: IndexBits];

  // RAM outputs belong to the buffered request while in lookup
  assign hit0 = tagRdata0.valid && (tagRdata0.tag == bufTag);
  assign hit1 = tagRdata1.valid && (tagRdata1.tag == bufTag);
  assign hit = hit0 || hit1;

  // a flush drops whatever is in lookup
  assign respOk = (state == Lookup) && hit && !flush;

  always_comb begin
    case (state)
      Idle:    addrOk = !replay || flush;  // pending replay blocks new requests
      Lookup:  addrOk = hit || flush;
      default: addrOk = 1'b0;
    endcase
  end

  assign accept = fetchReq.valid && addrOk;
  assign replayRead = (state == Idle) && replay && !flush;
  assign refillWr = (state == Refill) && refillRet.retValid;
  assign victim = lru[bufIndex];

  // tag and data RAMs share index, enable and write enables
  assign ramIndex = addrOk ? newIndex : bufIndex;
  assign tagEn = accept || replayRead || refillWr;
  assign tagWe0 = refillWr && !victim;
  assign tagWe1 = refillWr && victim;
  assign tagWdata = '{valid: 1'b1, tag: bufTag};
  assign dataWdata = refillRet.retData;

  // word select by offset bits 3:2
  assign word0 = dataRdata0[bufWord];
  assign word1 = dataRdata1[bufWord];

  assign fetchResp.dataOk = respOk;
  assign fetchResp.rdata = hit0 ? word0 : word1;

  // refill request held for the whole miss state
  assign refillReq.rdReq = (state == Miss);
  assign refillReq.rdAddr = {reqBuf[31:OffsetBits], {OffsetBits{1'b0}}};

  assign lookupEvt.accepted = accept;
  assign lookupEvt.miss = (state == Lookup) && !hit && !flush;

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (accept || replayRead) begin
          nextState = Lookup;
        end
      end
      Lookup: begin
        if (hit || flush) begin
          nextState = accept ? Lookup : Idle;  // back-to-back hits stay here
        end else begin
          nextState = Miss;
        end
      end
      Miss: begin
        if (rdRdy) begin
          nextState = Refill;
        end
      end
      Refill: begin
        if (refillRet.retValid) begin
          nextState = Idle;
        end
      end
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= Idle;
      replay <= 1'b0;
      flushPend <= 1'b0;
    end else begin
      state <= nextState;

      // replay only if no flush arrived since the miss
      if (refillWr) begin
        replay <= !(flushPend || flush);
      end else if (state == Idle) begin
        replay <= 1'b0;  // consumed by the replay read or dropped by flush
      end

      if (refillWr) begin
        flushPend <= 1'b0;
      end else if (flush && (state == Miss || state == Refill)) begin
        flushPend <= 1'b1;
      end
    end
  end

  // LRU bit names the way not used most recently
  always_ff @(posedge clk) begin
    if (!resetn) begin
      lru <= '0;
    end else if (respOk) begin
      lru[bufIndex] <= hit0;
    end else if (refillWr) begin
      lru[bufIndex] <= !victim;
    end
  end

  // request buffer, loaded on acceptance only
  always_ff @(posedge clk) begin
    if (accept) begin
      reqBuf <= fetchReq.addr;
    end
  end

endmodule

`default_nettype wire

// File: rtl/missCounter.sv
`default_nettype none

module missCounter #(
  parameter int CountWidth = 32
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  busPkg::lookupEvtT     lookupEvt,
  output logic [CountWidth-1:0] reqCount,
  output logic [CountWidth-1:0] missCount
);

  // both counters wrap at the top
  always_ff @(posedge clk) begin
    if (!resetn) begin
      reqCount <= '0;
      missCount <= '0;
    end else begin
      if (lookupEvt.accepted) begin
        reqCount <= reqCount + 1'b1;  // replays are never accepted
      end
      if (lookupEvt.miss) begin
        missCount <= missCount + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/instCacheTop.sv
`default_nettype none

module instCacheTop #(
  parameter int CountWidth = 32
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  busPkg::fetchReqT      fetchReq,
  output logic                  addrOk,
  output busPkg::fetchRespT     fetchResp,
  input  logic                  flush,
  output busPkg::refillReqT     refillReq,
  input  logic                  rdRdy,
  input  busPkg::refillRetT     refillRet,
  output logic [CountWidth-1:0] reqCount,
  output logic [CountWidth-1:0] missCount
);

  import cachePkg::*;
  import busPkg::*;

  logic                 tagEn;
  logic                 tagWe0;
  logic                 tagWe1;
  logic [IndexBits-1:0] ramIndex;
  tagEntryT             tagWdata;
  tagEntryT             tagRdata0;
  tagEntryT             tagRdata1;
  lineT                 dataWdata;
  lineT                 dataRdata0;
  lineT                 dataRdata1;
  lookupEvtT            lookupEvt;

  iCache u_iCache (
    .clk        (clk),
    .resetn     (resetn),
    .fetchReq   (fetchReq),
    .addrOk     (addrOk),
    .fetchResp  (fetchResp),
    .flush      (flush),
    .refillReq  (refillReq),
    .rdRdy      (rdRdy),
    .refillRet  (refillRet),
    .tagEn      (tagEn),
    .tagWe0     (tagWe0),
    .tagWe1     (tagWe1),
    .ramIndex   (ramIndex),
    .tagWdata   (tagWdata),
    .tagRdata0  (tagRdata0),
    .tagRdata1  (tagRdata1),
    .dataWdata  (dataWdata),
    .dataRdata0 (dataRdata0),
    .dataRdata1 (dataRdata1),
    .lookupEvt  (lookupEvt)
  );

  // way 0
  cacheRam #(.Depth(Sets), .payloadT(tagEntryT)) tagRam0 (
    .clk(clk), .en(tagEn), .we(tagWe0), .addr(ramIndex), .wdata(tagWdata), .rdata(tagRdata0)
  );
  cacheRam #(.Depth(Sets), .payloadT(lineT)) dataRam0 (
    .clk(clk), .en(tagEn), .we(tagWe0), .addr(ramIndex), .wdata(dataWdata), .rdata(dataRdata0)
  );

  // way 1
  cacheRam #(.Depth(Sets), .payloadT(tagEntryT)) tagRam1 (
    .clk(clk), .en(tagEn), .we(tagWe1), .addr(ramIndex), .wdata(tagWdata), .rdata(tagRdata1)
  );
  cacheRam #(.Depth(Sets), .payloadT(lineT)) dataRam1 (
    .clk(clk), .en(tagEn), .we(tagWe1), .addr(ramIndex), .wdata(dataWdata), .rdata(dataRdata1)
  );

  missCounter #(.CountWidth(CountWidth)) u_missCounter (
    .clk       (clk),
    .resetn    (resetn),
    .lookupEvt (lookupEvt),
    .reqCount  (reqCount),
    .missCount (missCount)
  );

endmodule

`default_nettype wire

// File: test/instCacheTests.svh
`ifndef INST_CACHE_TESTS_SVH
`define INST_CACHE_TESTS_SVH

logic [IndexBits-1:0] setIdx [4];
logic [TagBits-1:0]   tagA [4];
logic [TagBits-1:0]   tagB [4];

// random word within the line of tag and set
function automatic logic [31:0] makeAddr(input logic [TagBits-1:0] tag,
                                         input logic [IndexBits-1:0] idx);
  return {tag, idx, 2'(randBits(2)), 2'b00};
endfunction

// hitExp clear when the fetch should refill first
task automatic fetchOne(input logic [31:0] addr, input bit hitExp);
  int logSize;
  int n;
  logSize = rdAddrLog.size();
  @(posedge clk);
  #10;
  fetchReq = '{valid: 1'b1, addr: addr};
  n = 0;
  @(negedge clk);
  while (!addrOk) begin
    n++;
    assert (n < WaitLimit) else reportFail("request was never accepted");
    @(negedge clk);
  end
  @(posedge clk);
  #10;
  fetchReq.valid = 1'b0;
  acceptedCnt++;
  @(negedge clk);
  if (!hitExp) begin
    assert (!fetchResp.dataOk && !addrOk) else reportFail("missing lookup did not stall");
    missCnt++;
    n = 0;
    while (!fetchResp.dataOk) begin
      n++;
      assert (n < WaitLimit) else reportFail("no dataOk after the refill");
      @(negedge clk);
    end
    assert (rdAddrLog.size() == logSize + 1) else reportFail("dataOk without one refill");
    assert (rdAddrLog[$] == {addr[31:4], 4'h0}) else
      reportFail($sformatf("Error: refillReq.rdAddr is %h, expected %h",
                           rdAddrLog[$], {addr[31:4], 4'h0}));
  end
  checkResp(addr);
endtask

// two cold misses per set
task automatic fillSets();
  logic [IndexBits-1:0] base;
  int                   k;
  base = IndexBits'(randBits(IndexBits));
  for (k = 0; k < 4; k++) begin
    setIdx[k] = base + IndexBits'(k * 37);
    tagA[k] = TagBits'(randBits(TagBits));
    tagB[k] = tagA[k] ^ 20'h80001;
    rdyDelay = int'(randBits(2));
    retDelay = int'(randBits(2));
    fetchOne(makeAddr(tagA[k], setIdx[k]), 1'b0);
    fetchOne(makeAddr(tagB[k], setIdx[k]), 1'b0);
  end
endtask

task automatic streamHits();
  logic [31:0] addrs [8];
  int          i;
  int          logSize;
  for (i = 0; i < 8; i++) begin
    addrs[i] = makeAddr((randBits(1) != 0) ? tagB[i % 4] : tagA[i % 4], setIdx[i % 4]);
  end
  logSize = rdAddrLog.size();
  @(posedge clk);
  #10;
  for (i = 0; i < 8; i++) begin
    fetchReq = '{valid: 1'b1, addr: addrs[i]};
    @(negedge clk);
    assert (addrOk) else reportFail("hit stream stalled");
    if (i > 0) begin
      checkResp(addrs[i-1]);  // response to the previous request
    end
    @(posedge clk);
    #10;
    acceptedCnt++;
  end
  fetchReq.valid = 1'b0;
  @(negedge clk);
  checkResp(addrs[7]);
  assert (rdAddrLog.size() == logSize) else reportFail("refill requested during hit stream");
endtask

task automatic lruReplace();
  logic [TagBits-1:0] tagC;
  tagC = tagA[0] ^ 20'h00100;
  rdyDelay = 0;
  retDelay = 1;
  fetchOne(makeAddr(tagA[0], setIdx[0]), 1'b1);  // tagB now least recent
  fetchOne(makeAddr(tagC, setIdx[0]), 1'b0);     // replaces tagB
  fetchOne(makeAddr(tagA[0], setIdx[0]), 1'b1);
  fetchOne(makeAddr(tagB[0], setIdx[0]), 1'b0);
endtask

task automatic refillBackPressure();
  rdyDelay = 3 + int'(randBits(3));
  retDelay = int'(randBits(2));
  fetchOne(makeAddr(tagA[1] ^ 20'h00100, setIdx[1]), 1'b0);
endtask

task automatic flushCases();
  logic [31:0] missAddr;
  logic [31:0] hitAddr;
  int          logSize;
  int          n;
  // flush during the missing lookup with a hit presented alongside
  missAddr = makeAddr(tagA[2] ^ 20'h00100, setIdx[2]);
  hitAddr = makeAddr(tagA[3], setIdx[3]);
  logSize = rdAddrLog.size();
  @(posedge clk);
  #10;
  fetchReq = '{valid: 1'b1, addr: missAddr};
  @(negedge clk);
  assert (addrOk) else reportFail("idle cache did not accept");
  @(posedge clk);
  #10;
  flush = 1'b1;
  fetchReq.addr = hitAddr;
  @(negedge clk);
  assert (addrOk && !fetchResp.dataOk) else reportFail("flushed lookup answered or stalled");
  @(posedge clk);
  #10;
  flush = 1'b0;
  fetchReq.valid = 1'b0;
  acceptedCnt += 2;
  @(negedge clk);
  checkResp(hitAddr);
  repeat (4) begin
    @(negedge clk);
    assert (!fetchResp.dataOk) else reportFail("dataOk for a flushed request");
  end
  assert (rdAddrLog.size() == logSize) else reportFail("refill for a flushed lookup");

  // flush while the line is on its way back
  missAddr = makeAddr(tagB[2] ^ 20'h00100, setIdx[2]);
  rdyDelay = 1;
  retDelay = 3;
  @(posedge clk);
  #10;
  fetchReq = '{valid: 1'b1, addr: missAddr};
  @(negedge clk);
  assert (addrOk) else reportFail("idle cache did not accept");
  @(posedge clk);
  #10;
  fetchReq.valid = 1'b0;
  acceptedCnt++;
  missCnt++;
  n = 0;
  @(negedge clk);
  while (!refillReq.rdReq) begin
    n++;
    assert (n < WaitLimit) else reportFail("no refill request for the miss");
    @(negedge clk);
  end
  n = 0;
  while (refillReq.rdReq) begin
    n++;
    assert (n < WaitLimit) else reportFail("refill transfer never happened");
    @(negedge clk);
  end
  @(posedge clk);
  #10;
  flush = 1'b1;
  @(posedge clk);
  #10;
  flush = 1'b0;
  n = 0;
  @(negedge clk);
  while (!addrOk) begin
    assert (!fetchResp.dataOk) else reportFail("dataOk for a request flushed in refill");
    n++;
    assert (n < WaitLimit) else reportFail("cache never returned to idle");
    @(negedge clk);
  end
  assert (!fetchResp.dataOk) else reportFail("dataOk for a request flushed in refill");
  assert (rdAddrLog.size() == logSize + 1) else
    reportFail("wrong number of refills for the flushed miss");
  assert (rdAddrLog[$] == {missAddr[31:4], 4'h0}) else
    reportFail($sformatf("Error: refillReq.rdAddr is %h, expected %h",
                         rdAddrLog[$], {missAddr[31:4], 4'h0}));
  rdyDelay = 0;
  retDelay = 0;
  fetchOne(missAddr, 1'b1);  // line written in spite of the flush
endtask

task automatic checkCounters();
  @(negedge clk);
  assert (reqCount == CountWidth'(acceptedCnt)) else
    reportFail($sformatf("Error: reqCount is %h, expected %h", reqCount, acceptedCnt));
  assert (missCount == CountWidth'(missCnt)) else
    reportFail($sformatf("Error: missCount is %h, expected %h", missCount, missCnt));
endtask

`endif

// File: test/instCacheTb.sv
`default_nettype none

module instCacheTb;

  import cachePkg::*;
  import busPkg::*;

  localparam int CountWidth = 32;
  localparam int WaitLimit = 200;  // cycles per wait loop

  logic                  clk;
  logic                  resetn;
  fetchReqT              fetchReq;
  logic                  addrOk;
  fetchRespT             fetchResp;
  logic                  flush;
  refillReqT             refillReq;
  logic                  rdRdy;
  refillRetT             refillRet;
  logic [CountWidth-1:0] reqCount;
  logic [CountWidth-1:0] missCount;

  int          rdyDelay;      // cycles of rdRdy low before the transfer
  int          retDelay;      // cycles between transfer and retValid
  logic [31:0] rdAddrLog [$];
  int          acceptedCnt;
  int          missCnt;
  logic [31:0] lfsr = 32'h6c9c_5314;

  instCacheTop #(.CountWidth(CountWidth)) i_instCacheTop (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic reportFail(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] modelWord(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  function automatic lineT modelLine(input logic [31:0] lineAddr);
    lineT line;
    int   w;
    for (w = 0; w < WordsPerLine; w++) begin
      line[w] = modelWord(lineAddr + 32'(4 * w));
    end
    return line;
  endfunction

  task automatic checkResp(input logic [31:0] addr);
    assert (fetchResp.dataOk) else reportFail("dataOk missing in the expected cycle");
    assert (fetchResp.rdata == modelWord(addr)) else
      reportFail($sformatf("Error: fetchResp.rdata is %h, expected %h",
                           fetchResp.rdata, modelWord(addr)));
  endtask

  // refill memory, one line per rdReq
  initial begin : memModel
    logic [31:0] reqAddr;
    int          i;
    rdRdy = 1'b0;
    refillRet = '0;
    forever begin
      @(negedge clk);
      if (resetn && refillReq.rdReq) begin
        reqAddr = refillReq.rdAddr;
        rdAddrLog.push_back(reqAddr);
        for (i = 0; i < rdyDelay; i++) begin
          @(negedge clk);
          assert (refillReq.rdReq && !addrOk) else
            reportFail("rdReq dropped or addrOk rose while rdRdy was low");
          assert (refillReq.rdAddr == reqAddr) else
            reportFail($sformatf("Error: refillReq.rdAddr is %h, expected %h",
                                 refillReq.rdAddr, reqAddr));
        end
        @(posedge clk);
        #10;
        rdRdy = 1'b1;
        @(posedge clk);
        #10;
        rdRdy = 1'b0;  // transfer done
        for (i = 0; i < retDelay; i++) begin
          @(posedge clk);
          #10;
        end
        refillRet = '{retValid: 1'b1, retData: modelLine(reqAddr)};
        @(posedge clk);
        #10;
        refillRet.retValid = 1'b0;
      end
    end
  end

  `include "instCacheTests.svh"

  initial begin
    fetchReq = '0;
    flush = 1'b0;
    rdyDelay = 0;
    retDelay = 0;
    acceptedCnt = 0;
    missCnt = 0;
    resetn = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    resetn = 1'b1;
    @(negedge clk);
    assert (addrOk && !refillReq.rdReq && !fetchResp.dataOk) else
      reportFail("outputs not idle after reset");
    assert (reqCount == 0 && missCount == 0) else reportFail("counters not cleared by reset");
    fillSets();
    streamHits();
    lruReplace();
    refillBackPressure();
    flushCases();
    checkCounters();
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+test
rtl/cachePkg.sv
rtl/busPkg.sv
rtl/cacheRam.sv
rtl/iCache.sv
rtl/missCounter.sv
rtl/instCacheTop.sv
test/instCacheTb.sv

// File: run.sh
#!/bin/sh
# compile and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f build.f --top-module instCacheTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/VinstCacheTb
if [ $? -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi

exit 0
